// File: compile.f
img_pkg.sv
cfg_regs.sv
black_level.sv
gain.sv
isp_top.sv
isp_assertions.sv
tb_isp.sv

// File: Makefile
# Verilator build of the ISP testbench
# the simulator binary is rebuilt only when a source or the file list changes

SIM  := obj_dir/Vtb_isp
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_isp -f compile.f

# a failing run stops with a fatal error, so the binary exits non-zero
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: tb_isp.sv
// testbench for isp_top with table-driven frames, a reference model,
// an output monitor and a watchdog
`timescale 1ns/1ns

module tb_isp
   import img_pkg::*;
();

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 10;
   localparam int NROWS       = 6;
   // frame start, four rows of row start, four pixels and row end, frame end
   localparam int BEATS_PER_FRAME = 26;
   // nine valid writes and two to unmapped addresses take two cycles each
   localparam int WRITE_CYCLES = 22;
   localparam int DRAIN_CYCLES = 4;

   logic      clk;
   logic      resetb;
   logic      cfg_wr;
   cfg_addr_t cfg_addr;
   data_t     cfg_wdata;
   logic      dvi;
   dtype_t    dtypei;
   data_t     datai;
   logic      dvo;
   dtype_t    dtypeo;
   data_t     datao;

   int seed = 32'h70d6;

   // each test row holds the control word, the gains and offsets by channel 00 01 10 11,
   // the gap mode, the frame count and the extra writes to unmapped addresses
   logic [1:0] tab_ctrl [NROWS] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd3};
   gain_t tab_gain [NROWS][4] = '{
      '{8'd64,  8'd200, 8'd255, 8'd100},
      '{8'd90,  8'd250, 8'd32,  8'd160},
      '{8'd128, 8'd64,  8'd200, 8'd255},
      '{8'd144, 8'd96,  8'd180, 8'd255},
      '{8'd100, 8'd160, 8'd128, 8'd220},
      '{8'd100, 8'd160, 8'd128, 8'd220}};
   pixel_t tab_ofs [NROWS][4] = '{
      '{10'd50,  10'd50,  10'd50,  10'd50},
      '{10'd16,  10'd64,  10'd256, 10'd1023},
      '{10'd0,   10'd0,   10'd0,   10'd0},
      '{10'd32,  10'd48,  10'd64,  10'd80},
      '{10'd10,  10'd20,  10'd500, 10'd5},
      '{10'd10,  10'd20,  10'd500, 10'd5}};
   bit tab_gap    [NROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
   int tab_frames [NROWS] = '{1, 1, 1, 1, 2, 2};
   bit tab_bad_wr [NROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

   // reference copy of the registers and of each stage's Bayer phase
   logic   m_black_en = 1'b0;
   logic   m_gain_en  = 1'b0;
   gain_t  m_gain [4] = '{8'd0, 8'd0, 8'd0, 8'd0};
   pixel_t m_ofs  [4] = '{10'd0, 10'd0, 10'd0, 10'd0};
   bit     bl_row = 1'b0;
   bit     bl_col = 1'b0;
   bit     gn_row = 1'b0;
   bit     gn_col = 1'b0;

   // expected output beats in arrival order
   dtype_t exp_type [$];
   data_t  exp_data [$];

   isp_top i_isp_top (
      .clk       (clk),
      .resetb    (resetb),
      .cfg_wr    (cfg_wr),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .dvi       (dvi),
      .dtypei    (dtypei),
      .datai     (datai),
      .dvo       (dvo),
      .dtypeo    (dtypeo),
      .datao     (datao)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task abort_run;
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task check(input string name, input logic [15:0] actual, input logic [15:0] expected);
      if (actual !== expected) begin
         $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
         abort_run();
      end
   endtask

   // pixel minus offset with a floor at zero
   function automatic data_t black_ref(input data_t d, input pixel_t ofs);
      pixel_t p;
      p = d[PIXEL_WIDTH-1:0];
      if (p < ofs) return '0;
      return data_t'(p - ofs);
   endfunction

   // pixel times 1.7 gain, saturated at full scale
   function automatic data_t gain_ref(input data_t d, input gain_t g);
      int scaled;
      scaled = (int'(d[PIXEL_WIDTH-1:0]) * int'(g)) / (1 << GAIN_FRAC_WIDTH);
      if (scaled > int'(PIXEL_MAX)) return data_t'(PIXEL_MAX);
      return data_t'(scaled);
   endfunction

   // expected result of one valid input beat after both stages
   task model_beat(input dtype_t dtype, input data_t data);
      data_t d;
      d = data;
      if (m_black_en) begin
         if (dtype == DTYPE_FRAME_START) begin
            bl_row = 1'b1;
            bl_col = 1'b0;
         end else if (dtype == DTYPE_ROW_START) begin
            bl_row = ~bl_row;
            bl_col = 1'b0;
         end else if (dtype == DTYPE_PIXEL) begin
            d = black_ref(d, m_ofs[{bl_row, bl_col}]);
            bl_col = ~bl_col;
         end
      end
      // the gain stage sees the black level output
      if (m_gain_en) begin
         if (dtype == DTYPE_FRAME_START) begin
            gn_row = 1'b1;
            gn_col = 1'b0;
         end else if (dtype == DTYPE_ROW_START) begin
            gn_row = ~gn_row;
            gn_col = 1'b0;
         end else if (dtype == DTYPE_PIXEL) begin
            d = gain_ref(d, m_gain[{gn_row, gn_col}]);
            gn_col = ~gn_col;
         end
      end
      exp_type.push_back(dtype);
      exp_data.push_back(d);
   endtask

   task wait_drive_point;
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic write_reg(input cfg_addr_t addr, input data_t wdata);
      int idx;
      idx = int'(addr);
      wait_drive_point();
      cfg_wr    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = wdata;
      wait_drive_point();
      cfg_wr = 1'b0;
      // registers take the low bits and other addresses are ignored
      if (addr == REG_CTRL) begin
         m_black_en = wdata[0];
         m_gain_en  = wdata[1];
      end else if (idx >= int'(REG_GAIN00) && idx <= int'(REG_GAIN11)) begin
         m_gain[idx - int'(REG_GAIN00)] = gain_t'(wdata);
      end else if (idx >= int'(REG_OFS00) && idx <= int'(REG_OFS11)) begin
         m_ofs[idx - int'(REG_OFS00)] = pixel_t'(wdata);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         wait_drive_point();
         dvi = 1'b0;
         // a row start code without valid must not move the phase
         dtypei = DTYPE_ROW_START;
         datai  = data_t'($random(seed));
      end
   endtask

   task automatic send_beat(input dtype_t dtype, input data_t data, input bit gap);
      int idle;
      idle = gap ? ($random(seed) & 3) : 0;
      idle_cycles(idle);
      wait_drive_point();
      dvi    = 1'b1;
      dtypei = dtype;
      datai  = data;
      model_beat(dtype, data);
   endtask

   // control beats carry junk with the top data bit set
   task automatic send_ctrl(input dtype_t dtype, input bit gap);
      data_t d;
      d = data_t'($random(seed));
      d[DATA_WIDTH-1] = 1'b1;
      send_beat(dtype, d, gap);
   endtask

   task automatic send_frame(input bit gap);
      send_ctrl(DTYPE_FRAME_START, gap);
      for (int row = 0; row < 4; row++) begin
         send_ctrl(DTYPE_ROW_START, gap);
         for (int col = 0; col < 4; col++) begin
            // pixel beats also carry junk above the raw pixel bits
            send_beat(DTYPE_PIXEL, data_t'($random(seed)), gap);
         end
         send_ctrl(DTYPE_ROW_END, gap);
      end
      send_ctrl(DTYPE_FRAME_END, gap);
   endtask

   task automatic program_row(input int r);
      write_reg(REG_CTRL, data_t'(tab_ctrl[r]));
      for (int i = 0; i < 4; i++) begin
         write_reg(cfg_addr_t'(int'(REG_GAIN00) + i), data_t'(tab_gain[r][i]));
      end
      for (int i = 0; i < 4; i++) begin
         write_reg(cfg_addr_t'(int'(REG_OFS00) + i), data_t'(tab_ofs[r][i]));
      end
      if (tab_bad_wr[r]) begin
         write_reg(4'd9, '1);
         write_reg(4'd15, '1);
      end
   endtask

   // the monitor samples the outputs at the falling edge where they are stable
   always @(negedge clk) begin : monitor
      if (resetb && dvo) begin
         if (exp_type.size() == 0) begin
            $display("the DUT produced an output beat that no input beat explains");
            abort_run();
         end else begin
            check("dtypeo", 16'(dtypeo), 16'(exp_type.pop_front()));
            check("datao", datao, exp_data.pop_front());
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 8;
      for (int r = 0; r < NROWS; r++) begin
         cycles += WRITE_CYCLES + DRAIN_CYCLES;
         cycles += tab_frames[r] * BEATS_PER_FRAME * (tab_gap[r] ? 4 : 1);
      end
      #(2 * cycles * CLK_PERIOD);
      $display("timeout, the tests did not finish in the allowed time");
      abort_run();
   end

   initial begin : stimulus
      resetb    = 1'b0;
      cfg_wr    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      dvi       = 1'b0;
      dtypei    = '0;
      datai     = '0;
      repeat (4) wait_drive_point();
      resetb = 1'b1;
      check("dvo", 16'(dvo), 16'h0);
      check("dtypeo", 16'(dtypeo), 16'h0);
      check("datao", datao, 16'h0);
      for (int r = 0; r < NROWS; r++) begin
         program_row(r);
         repeat (tab_frames[r]) send_frame(tab_gap[r]);
         // two cycles of pipeline mean every beat is out after the drain
         idle_cycles(DRAIN_CYCLES);
         if (exp_type.size() != 0) begin
            $display("%0d expected beats were lost in table row %0d", exp_type.size(), r);
            abort_run();
         end
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: isp_assertions.sv
// concurrent checks on the isp_top stream latency and on the data of
// control beats, bound into isp_top
`timescale 1ns/1ns

module isp_assertions
   import img_pkg::*;
(
   input logic   clk,
   input logic   resetb,
   input logic   dvi,
   input dtype_t dtypei,
   input data_t  datai,
   input logic   dvo,
   input dtype_t dtypeo,
   input data_t  datao
);

   // counts the first cycles after reset so that $past sees real history
   logic [1:0] settle;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         settle <= '0;
      end else if (settle != 2'd3) begin
         settle <= settle + 2'd1;
      end
   end

   a_dv_latency: assert property (@(posedge clk) disable iff (!resetb)
      (settle >= 2'd2) |-> (dvo == $past(dvi, 2)))
      else $error("dvo does not follow dvi two cycles later");

   a_dtype_latency: assert property (@(posedge clk) disable iff (!resetb)
      (settle >= 2'd2) |-> (dtypeo == $past(dtypei, 2)))
      else $error("dtypeo does not follow dtypei two cycles later");

   // frame and row beats leave with the data they came in with
   a_ctrl_data: assert property (@(posedge clk) disable iff (!resetb)
      (settle >= 2'd2 && dvo && dtypeo != DTYPE_PIXEL) |-> (datao == $past(datai, 2)))
      else $error("a control beat lost its data");

endmodule

bind isp_top isp_assertions i_isp_assertions (
   .clk    (clk),
   .resetb (resetb),
   .dvi    (dvi),
   .dtypei (dtypei),
   .datai  (datai),
   .dvo    (dvo),
   .dtypeo (dtypeo),
   .datao  (datao)
);

// File: isp_top.sv
// raw image front end with the register block, black level and gain
// stages chained on one pixel stream
`timescale 1ns/1ns

module isp_top
   import img_pkg::*;
(
   input  logic      clk,
   input  logic      resetb,
   input  logic      cfg_wr,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   input  logic      dvi,
   input  dtype_t    dtypei,
   input  data_t     datai,
   output logic      dvo,
   output dtype_t    dtypeo,
   output data_t     datao
);

   // stage enables and coefficients from the register block
   logic   black_en;
   logic   gain_en;
   gain_t  gain00;
   gain_t  gain01;
   gain_t  gain10;
   gain_t  gain11;
   pixel_t ofs00;
   pixel_t ofs01;
   pixel_t ofs10;
   pixel_t ofs11;

   // stream between black level and gain, one cycle behind the input
   logic   bl_dv;
   dtype_t bl_dtype;
   data_t  bl_data;

   cfg_regs i_cfg_regs (
      .clk       (clk),
      .resetb    (resetb),
      .cfg_wr    (cfg_wr),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .black_en  (black_en),
      .gain_en   (gain_en),
      .gain00    (gain00),
      .gain01    (gain01),
      .gain10    (gain10),
      .gain11    (gain11),
      .ofs00     (ofs00),
      .ofs01     (ofs01),
      .ofs10     (ofs10),
      .ofs11     (ofs11)
   );

   // black level runs first so that gain sees offset-free pixels
   black_level i_black_level (
      .clk    (clk),
      .resetb (resetb),
      .enable (black_en),
      .ofs00  (ofs00),
      .ofs01  (ofs01),
      .ofs10  (ofs10),
      .ofs11  (ofs11),
      .dvi    (dvi),
      .dtypei (dtypei),
      .datai  (datai),
      .dvo    (bl_dv),
      .dtypeo (bl_dtype),
      .datao  (bl_data)
   );

   gain i_gain (
      .clk    (clk),
      .resetb (resetb),
      .enable (gain_en),
      .gain00 (gain00),
      .gain01 (gain01),
      .gain10 (gain10),
      .gain11 (gain11),
      .dvi    (bl_dv),
      .dtypei (bl_dtype),
      .datai  (bl_data),
      .dvo    (dvo),
      .dtypeo (dtypeo),
      .datao  (datao)
   );

endmodule

// File: gain.sv
// white balance gain stage that scales each raw pixel by a per-channel
// 1.7 fixed-point gain and clamps on overflow
`timescale 1ns/1ns

module gain
   import img_pkg::*;
(
   input  logic   clk,
   input  logic   resetb,
   input  logic   enable,
   input  gain_t  gain00,
   input  gain_t  gain01,
   input  gain_t  gain10,
   input  gain_t  gain11,
   input  logic   dvi,
   input  dtype_t dtypei,
   input  data_t  datai,
   output logic   dvo,
   output dtype_t dtypeo,
   output data_t  datao
);

   // current Bayer position of the incoming beat
   phase_t phase;

   // gain for the current channel
   gain_t gain_sel;

   // raw pixel taken from the low data bits
   pixel_t pix;

   // full product, 18 bits with the binary point above bit 6
   logic [PROD_WIDTH-1:0] prod;

   // anything at or above this bit no longer fits in a pixel
   logic overflow;

   // scaled pixel after the clamp
   pixel_t pix_out;

   // the beat is a pixel that this stage must change
   logic do_pixel;

   assign pix = datai[PIXEL_WIDTH-1:0];

   // phase bits are {row, col}, matching the coefficient suffixes
   always_comb begin
      case (phase)
         2'b00:   gain_sel = gain00;
         2'b01:   gain_sel = gain01;
         2'b10:   gain_sel = gain10;
         default: gain_sel = gain11;
      endcase
   end

   assign prod = PROD_WIDTH'(pix) * PROD_WIDTH'(gain_sel);

   // with one integer gain bit only the top product bit can overflow
   assign overflow = |prod[PROD_WIDTH-1:PIXEL_WIDTH+GAIN_FRAC_WIDTH];

   // drop the fraction bits, or saturate to full scale
   assign pix_out = overflow ? PIXEL_MAX
                             : prod[PIXEL_WIDTH+GAIN_FRAC_WIDTH-1:GAIN_FRAC_WIDTH];

   assign do_pixel = enable && dvi && (dtypei == DTYPE_PIXEL);

   // each stage keeps its own phase so a disabled neighbour cannot upset it
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         phase <= '0;
      end else if (enable && dvi) begin
         phase <= next_phase(dtypei, phase);
      end
   end

   // one cycle of latency for every beat, valid or not
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo    <= 1'b0;
         dtypeo <= '0;
         datao  <= '0;
      end else begin
         dvo    <= dvi;
         dtypeo <= dtypei;
         // control beats and a disabled stage leave the data untouched
         if (do_pixel) begin
            datao <= data_t'(pix_out);
         end else begin
            datao <= datai;
         end
      end
   end

endmodule

// File: black_level.sv
// black level stage that subtracts a per-channel offset from each raw
// pixel and floors the result at zero
`timescale 1ns/1ns

module black_level
   import img_pkg::*;
(
   input  logic   clk,
   input  logic   resetb,
   input  logic   enable,
   input  pixel_t ofs00,
   input  pixel_t ofs01,
   input  pixel_t ofs10,
   input  pixel_t ofs11,
   input  logic   dvi,
   input  dtype_t dtypei,
   input  data_t  datai,
   output logic   dvo,
   output dtype_t dtypeo,
   output data_t  datao
);

   // current Bayer position of the incoming beat
   phase_t phase;

   // offset for the current channel
   pixel_t ofs_sel;

   // raw pixel taken from the low data bits
   pixel_t pix;

   // difference with one extra bit that catches the borrow
   logic [PIXEL_WIDTH:0] diff;

   // offset-subtracted pixel after the floor
   pixel_t pix_out;

   // the beat is a pixel that this stage must change
   logic do_pixel;

   assign pix = datai[PIXEL_WIDTH-1:0];

   // phase bits are {row, col}, matching the coefficient suffixes
   always_comb begin
      case (phase)
         2'b00:   ofs_sel = ofs00;
         2'b01:   ofs_sel = ofs01;
         2'b10:   ofs_sel = ofs10;
         default: ofs_sel = ofs11;
      endcase
   end

   assign diff = {1'b0, pix} - {1'b0, ofs_sel};

   // a borrow out of the top means the offset was larger than the pixel
   assign pix_out = diff[PIXEL_WIDTH] ? '0 : diff[PIXEL_WIDTH-1:0];

   assign do_pixel = enable && dvi && (dtypei == DTYPE_PIXEL);

   // phase only moves on valid beats while the stage is enabled
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         phase <= '0;
      end else if (enable && dvi) begin
         phase <= next_phase(dtypei, phase);
      end
   end

   // one cycle of latency for every beat, valid or not
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo    <= 1'b0;
         dtypeo <= '0;
         datao  <= '0;
      end else begin
         dvo    <= dvi;
         dtypeo <= dtypei;
         // processed pixels carry zeros in the upper data bits
         if (do_pixel) begin
            datao <= data_t'(pix_out);
         end else begin
            datao <= datai;
         end
      end
   end

endmodule

// File: cfg_regs.sv
// configuration registers for the pixel stages, loaded by a one-cycle
// write strobe with an address and a data word
`timescale 1ns/1ns

module cfg_regs
   import img_pkg::*;
(
   input  logic      clk,
   input  logic      resetb,
   input  logic      cfg_wr,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   output logic      black_en,
   output logic      gain_en,
   output gain_t     gain00,
   output gain_t     gain01,
   output gain_t     gain10,
   output gain_t     gain11,
   output pixel_t    ofs00,
   output pixel_t    ofs01,
   output pixel_t    ofs10,
   output pixel_t    ofs11
);

   // write data cut down to each register width
   gain_t  wr_gain;
   pixel_t wr_ofs;

   assign wr_gain = cfg_wdata[GAIN_WIDTH-1:0];
   assign wr_ofs  = cfg_wdata[PIXEL_WIDTH-1:0];

   // every register comes out of reset as zero
   // so both stages start disabled with zero coefficients
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         black_en <= 1'b0;
         gain_en  <= 1'b0;
         gain00   <= '0;
         gain01   <= '0;
         gain10   <= '0;
         gain11   <= '0;
         ofs00    <= '0;
         ofs01    <= '0;
         ofs10    <= '0;
         ofs11    <= '0;
      end else if (cfg_wr) begin
         // one register per strobe, picked by address
         case (cfg_addr)
            REG_CTRL: begin
               black_en <= cfg_wdata[CTRL_BLACK_EN_BIT];
               gain_en  <= cfg_wdata[CTRL_GAIN_EN_BIT];
            end
            REG_GAIN00: begin
               gain00 <= wr_gain;
            end
            REG_GAIN01: begin
               gain01 <= wr_gain;
            end
            REG_GAIN10: begin
               gain10 <= wr_gain;
            end
            REG_GAIN11: begin
               gain11 <= wr_gain;
            end
            REG_OFS00: begin
               ofs00 <= wr_ofs;
            end
            REG_OFS01: begin
               ofs01 <= wr_ofs;
            end
            REG_OFS10: begin
               ofs10 <= wr_ofs;
            end
            REG_OFS11: begin
               ofs11 <= wr_ofs;
            end
            // unmapped addresses leave all registers as they are
            default: begin
            end
         endcase
      end
   end

endmodule

// File: img_pkg.sv
// shared stream widths, beat type codes, register addresses and the
// Bayer phase update used by both pixel stages
package img_pkg;

   // beat type of the pixel stream
   localparam int DTYPE_WIDTH = 3;
   typedef logic [DTYPE_WIDTH-1:0] dtype_t;

   localparam dtype_t DTYPE_FRAME_START = 3'd1;
   localparam dtype_t DTYPE_ROW_START   = 3'd2;
   localparam dtype_t DTYPE_PIXEL       = 3'd3;
   localparam dtype_t DTYPE_ROW_END     = 3'd4;
   localparam dtype_t DTYPE_FRAME_END   = 3'd5;

   // raw pixels sit in the low bits of the wider stream data word
   localparam int PIXEL_WIDTH = 10;
   localparam int DATA_WIDTH  = 16;
   typedef logic [PIXEL_WIDTH-1:0] pixel_t;
   typedef logic [DATA_WIDTH-1:0]  data_t;

   // largest raw pixel value, used as the clamp level
   localparam pixel_t PIXEL_MAX = '1;

   // gain is unsigned 1.7 fixed point, so 128 is unity
   localparam int GAIN_WIDTH      = 8;
   localparam int GAIN_FRAC_WIDTH = 7;
   typedef logic [GAIN_WIDTH-1:0] gain_t;

   // full width of pixel times gain
   localparam int PROD_WIDTH = PIXEL_WIDTH + GAIN_WIDTH;

   // configuration register map
   localparam int CFG_ADDR_WIDTH = 4;
   typedef logic [CFG_ADDR_WIDTH-1:0] cfg_addr_t;

   localparam cfg_addr_t REG_CTRL   = 4'd0;
   localparam cfg_addr_t REG_GAIN00 = 4'd1;
   localparam cfg_addr_t REG_GAIN01 = 4'd2;
   localparam cfg_addr_t REG_GAIN10 = 4'd3;
   localparam cfg_addr_t REG_GAIN11 = 4'd4;
   localparam cfg_addr_t REG_OFS00  = 4'd5;
   localparam cfg_addr_t REG_OFS01  = 4'd6;
   localparam cfg_addr_t REG_OFS10  = 4'd7;
   localparam cfg_addr_t REG_OFS11  = 4'd8;

   // stage enable bits inside the control register
   localparam int CTRL_BLACK_EN_BIT = 0;
   localparam int CTRL_GAIN_EN_BIT  = 1;

   // Bayer position as {row, col}, where a set bit means odd
   typedef logic [1:0] phase_t;

   // phase after a beat of the given type
   // a frame start leaves the row odd so that the first row start makes it even
   function automatic phase_t next_phase(input dtype_t dtype, input phase_t phase);
      case (dtype)
         DTYPE_FRAME_START: return 2'b10;
         DTYPE_ROW_START:   return {~phase[1], 1'b0};
         DTYPE_PIXEL:       return {phase[1], ~phase[0]};
         default:           return phase;
      endcase
   endfunction

endpackage
